// File: rtl/vwrite_settings.svh
`ifndef VWRITE_SETTINGS_SVH
`define VWRITE_SETTINGS_SVH

// Width of one stream and bus word
`define VW_DATA_W 32

// Local buffer address for 256 words
`define VW_ADDR_W 8
`define VW_MEM_DEPTH (1 << `VW_ADDR_W)

// Loop period and duty counters
`define VW_PERIOD_W 6

// Start delay counter
`define VW_DELAY_W 4

// Burst length field in beats minus one
`define VW_LEN_W 8

// External databus address
`define VW_EXT_ADDR_W 32

`endif

// File: rtl/vwrite_pkg.sv
`include "vwrite_settings.svh"

package vwrite_pkg;

   // One two-level loop nest
   typedef struct packed {
      logic [`VW_ADDR_W-1:0]   start;
      logic [`VW_PERIOD_W-1:0] period;
      logic [`VW_PERIOD_W-1:0] duty;
      logic [`VW_ADDR_W-1:0]   incr;
      logic [`VW_ADDR_W-1:0]   iterations;
      logic [`VW_ADDR_W-1:0]   shift;
      logic [`VW_PERIOD_W-1:0] period2;
      logic [`VW_ADDR_W-1:0]   incr2;
      logic [`VW_ADDR_W-1:0]   iterations2;
      logic [`VW_ADDR_W-1:0]   shift2;
      logic [`VW_DELAY_W-1:0]  delay;
   } addr_gen_cfg_t;

   // Held stable from run until done
   typedef struct packed {
      logic [`VW_EXT_ADDR_W-1:0] ext_addr;
      logic [`VW_LEN_W-1:0]      length;
      logic                      write_enabled;
      logic                      ping_pong;
      addr_gen_cfg_t             store;
      addr_gen_cfg_t             send;
   } write_cfg_t;

   typedef struct packed {
      logic                      valid;
      logic [`VW_EXT_ADDR_W-1:0] addr;
      logic [`VW_DATA_W-1:0]     wdata;
      logic [`VW_LEN_W-1:0]      len;
   } bus_req_t;

   typedef struct packed {
      logic ready;
      logic last;
   } bus_rsp_t;

   typedef enum logic [1:0] {
      GEN_IDLE,
      GEN_DELAY,
      GEN_RUN
   } gen_state_e;

endpackage

// File: rtl/address_gen.sv
`timescale 1ns/1ns
`include "vwrite_settings.svh"

module address_gen (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      run_i,
   input  vwrite_pkg::addr_gen_cfg_t cfg_i,
   input  logic                      ready_i,
   output logic                      valid_o,
   output logic [`VW_ADDR_W-1:0]     addr_o,
   output logic                      store_o,
   output logic                      done_o
);

   vwrite_pkg::gen_state_e state_q;

   logic [`VW_DELAY_W-1:0]  delay_cnt_q;
   logic [`VW_PERIOD_W-1:0] per_cnt_q;
   logic [`VW_ADDR_W-1:0]   iter_cnt_q;
   logic [`VW_PERIOD_W-1:0] per2_cnt_q;
   logic [`VW_ADDR_W-1:0]   iter2_cnt_q;
   logic [`VW_ADDR_W-1:0]   addr_q;
   logic [`VW_ADDR_W-1:0]   base2_q;
   logic [`VW_ADDR_W-1:0]   base2_next;
   logic                    done_q;

   // One past each index, so a zero limit acts as one
   logic [`VW_PERIOD_W:0] per_next;
   logic [`VW_ADDR_W:0]   iter_next;
   logic [`VW_PERIOD_W:0] per2_next;
   logic [`VW_ADDR_W:0]   iter2_next;
   logic                  per_last;
   logic                  iter_last;
   logic                  per2_last;
   logic                  iter2_last;
   logic                  step;

   assign per_next   = {1'b0, per_cnt_q} + 1'b1;
   assign iter_next  = {1'b0, iter_cnt_q} + 1'b1;
   assign per2_next  = {1'b0, per2_cnt_q} + 1'b1;
   assign iter2_next = {1'b0, iter2_cnt_q} + 1'b1;

   assign per_last   = per_next >= {1'b0, cfg_i.period};
   assign iter_last  = iter_next >= {1'b0, cfg_i.iterations};
   assign per2_last  = per2_next >= {1'b0, cfg_i.period2};
   assign iter2_last = iter2_next >= {1'b0, cfg_i.iterations2};

   assign step = (state_q == vwrite_pkg::GEN_RUN) && ready_i;

   // Outer level moves by incr2 inside a period2 group and by shift2 at its end
   assign base2_next = per2_last ? base2_q + cfg_i.shift2 : base2_q + cfg_i.incr2;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q     <= vwrite_pkg::GEN_IDLE;
         delay_cnt_q <= '0;
         per_cnt_q   <= '0;
         iter_cnt_q  <= '0;
         per2_cnt_q  <= '0;
         iter2_cnt_q <= '0;
         done_q      <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (run_i) begin
            if (cfg_i.delay != '0) begin
               state_q <= vwrite_pkg::GEN_DELAY;
            end else begin
               state_q <= vwrite_pkg::GEN_RUN;
            end
            delay_cnt_q <= cfg_i.delay;
            per_cnt_q   <= '0;
            iter_cnt_q  <= '0;
            per2_cnt_q  <= '0;
            iter2_cnt_q <= '0;
         end else if (state_q == vwrite_pkg::GEN_DELAY) begin
            delay_cnt_q <= delay_cnt_q - 1'b1;
            if (delay_cnt_q == 'd1) begin
               state_q <= vwrite_pkg::GEN_RUN;
            end
         end else if (step) begin
            if (!per_last) begin
               per_cnt_q <= per_cnt_q + 1'b1;
            end else begin
               per_cnt_q <= '0;
               if (!iter_last) begin
                  iter_cnt_q <= iter_cnt_q + 1'b1;
               end else begin
                  iter_cnt_q <= '0;
                  if (!per2_last) begin
                     per2_cnt_q <= per2_cnt_q + 1'b1;
                  end else if (!iter2_last) begin
                     per2_cnt_q  <= '0;
                     iter2_cnt_q <= iter2_cnt_q + 1'b1;
                  end else begin
                     state_q <= vwrite_pkg::GEN_IDLE;
                     done_q  <= 1'b1;
                  end
               end
            end
         end
      end
   end

   // At a period end the address moves by shift instead of incr
   always_ff @(posedge clk) begin
      if (run_i) begin
         addr_q  <= cfg_i.start;
         base2_q <= cfg_i.start;
      end else if (step) begin
         if (!per_last) begin
            addr_q <= addr_q + cfg_i.incr;
         end else if (!iter_last) begin
            addr_q <= addr_q + cfg_i.shift;
         end else if (!(per2_last && iter2_last)) begin
            addr_q  <= base2_next;
            base2_q <= base2_next;
         end
      end
   end

   assign valid_o = (state_q == vwrite_pkg::GEN_RUN);
   assign store_o = valid_o && (per_cnt_q < cfg_i.duty);
   assign addr_o  = addr_q;
   assign done_o  = done_q;

endmodule

// File: rtl/memory_reader.sv
`timescale 1ns/1ns
`include "vwrite_settings.svh"

module memory_reader (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start_over_i,
   input  logic                  s_valid_i,
   output logic                  s_ready_o,
   input  logic [`VW_ADDR_W-1:0] s_addr_i,
   output logic                  m_valid_o,
   output logic [`VW_DATA_W-1:0] m_data_o,
   input  logic                  m_ready_i,
   input  logic                  m_last_i,
   output logic                  mem_en_o,
   output logic [`VW_ADDR_W-1:0] mem_addr_o,
   input  logic [`VW_DATA_W-1:0] mem_data_i
);

   logic [`VW_DATA_W-1:0] skid_q [0:1];
   logic [1:0]            count_q;
   logic                  wr_ptr_q;
   logic                  rd_ptr_q;
   logic                  pending_q;
   logic                  ended_q;
   logic [2:0]            occupancy;
   logic                  issue;
   logic                  push;
   logic                  pop;
   logic                  last_beat;

   assign pop       = m_valid_o && m_ready_i;
   assign push      = pending_q;
   assign last_beat = pop && m_last_i;

   // Entries held plus the read returning now, less the one leaving
   assign occupancy = {1'b0, count_q} + {2'b00, pending_q} - {2'b00, pop};
   assign s_ready_o = !ended_q && (occupancy < 3'd2);
   assign issue     = s_valid_i && s_ready_o;

   assign mem_en_o   = issue;
   assign mem_addr_o = s_addr_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count_q   <= '0;
         wr_ptr_q  <= 1'b0;
         rd_ptr_q  <= 1'b0;
         pending_q <= 1'b0;
         ended_q   <= 1'b0;
      end else if (start_over_i || last_beat) begin
         // Drop everything, including a read still in flight
         count_q   <= '0;
         wr_ptr_q  <= 1'b0;
         rd_ptr_q  <= 1'b0;
         pending_q <= 1'b0;
         ended_q   <= !start_over_i;
      end else begin
         pending_q <= issue;
         if (push) begin
            wr_ptr_q <= !wr_ptr_q;
         end
         if (pop) begin
            rd_ptr_q <= !rd_ptr_q;
         end
         count_q <= count_q + {1'b0, push} - {1'b0, pop};
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         skid_q[wr_ptr_q] <= mem_data_i;
      end
   end

   assign m_valid_o = (count_q != 2'd0);
   assign m_data_o  = skid_q[rd_ptr_q];

endmodule

// File: rtl/buffer_ram.sv
`timescale 1ns/1ns
`include "vwrite_settings.svh"

module buffer_ram (
   input  logic                  clk,
   input  logic                  wr_en_i,
   input  logic [`VW_ADDR_W-1:0] wr_addr_i,
   input  logic [`VW_DATA_W-1:0] wr_data_i,
   input  logic                  rd_en_i,
   input  logic [`VW_ADDR_W-1:0] rd_addr_i,
   output logic [`VW_DATA_W-1:0] rd_data_o
);

   logic [`VW_DATA_W-1:0] mem_q [0:`VW_MEM_DEPTH-1];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem_q[wr_addr_i] <= wr_data_i;
      end
   end

   // Read returns the old word on a same-address write
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem_q[rd_addr_i];
      end
   end

endmodule

// File: rtl/vwrite_unit.sv
`timescale 1ns/1ns
`include "vwrite_settings.svh"

module vwrite_unit (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   run_i,
   input  vwrite_pkg::write_cfg_t cfg_i,
   input  logic [`VW_DATA_W-1:0]  in_data_i,
   input  vwrite_pkg::bus_rsp_t   bus_rsp_i,
   input  logic [`VW_DATA_W-1:0]  rd_data_i,
   output logic                   done_o,
   output vwrite_pkg::bus_req_t   bus_req_o,
   output logic                   wr_en_o,
   output logic [`VW_ADDR_W-1:0]  wr_addr_o,
   output logic [`VW_DATA_W-1:0]  wr_data_o,
   output logic                   rd_en_o,
   output logic [`VW_ADDR_W-1:0]  rd_addr_o
);

   vwrite_pkg::addr_gen_cfg_t store_cfg;
   vwrite_pkg::addr_gen_cfg_t send_cfg;

   logic                  write_done_q;
   logic                  store_done_q;
   logic                  toggle_q;
   logic                  store_valid;
   logic                  store_flag;
   logic                  store_gen_done;
   logic                  send_valid;
   logic                  send_flag;
   logic                  send_ready;
   logic [`VW_ADDR_W-1:0] send_addr;
   logic                  reader_ready;
   logic                  m_valid;
   logic [`VW_DATA_W-1:0] m_data;
   logic                  bus_valid;
   logic                  bus_ready;
   logic                  last_beat;

   // Ping-pong halves are picked by the top address bit
   always_comb begin
      store_cfg       = cfg_i.store;
      store_cfg.start = {cfg_i.ping_pong && toggle_q, cfg_i.store.start[`VW_ADDR_W-2:0]};
      send_cfg        = cfg_i.send;
      send_cfg.start  = {cfg_i.ping_pong && !toggle_q, {(`VW_ADDR_W-1){1'b0}}};
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         write_done_q <= 1'b1;
         store_done_q <= 1'b1;
         toggle_q     <= 1'b0;
      end else if (run_i) begin
         write_done_q <= !cfg_i.write_enabled;
         store_done_q <= 1'b0;
         toggle_q     <= cfg_i.ping_pong ? !toggle_q : 1'b0;
      end else begin
         if (store_gen_done) begin
            store_done_q <= 1'b1;
         end
         if (last_beat) begin
            write_done_q <= 1'b1;
         end
      end
   end

   assign done_o = write_done_q && store_done_q;

   address_gen store_gen (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i),
      .cfg_i   (store_cfg),
      .ready_i (1'b1),
      .valid_o (store_valid),
      .addr_o  (wr_addr_o),
      .store_o (store_flag),
      .done_o  (store_gen_done)
   );

   // Positions outside the duty window are skipped without a read
   assign send_ready = reader_ready || !send_flag;

   address_gen send_gen (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i && cfg_i.write_enabled),
      .cfg_i   (send_cfg),
      .ready_i (send_ready),
      .valid_o (send_valid),
      .addr_o  (send_addr),
      .store_o (send_flag),
      .done_o  ()
   );

   memory_reader reader (
      .clk          (clk),
      .rst          (rst),
      .start_over_i (run_i),
      .s_valid_i    (send_valid && send_flag),
      .s_ready_o    (reader_ready),
      .s_addr_i     (send_addr),
      .m_valid_o    (m_valid),
      .m_data_o     (m_data),
      .m_ready_i    (bus_ready),
      .m_last_i     (bus_rsp_i.last),
      .mem_en_o     (rd_en_o),
      .mem_addr_o   (rd_addr_o),
      .mem_data_i   (rd_data_i)
   );

   assign bus_valid = m_valid && !write_done_q;
   assign bus_ready = bus_rsp_i.ready && !write_done_q;
   assign last_beat = bus_valid && bus_rsp_i.ready && bus_rsp_i.last;

   always_comb begin
      bus_req_o.valid = bus_valid;
      bus_req_o.addr  = cfg_i.ext_addr;
      bus_req_o.wdata = m_data;
      bus_req_o.len   = cfg_i.length;
   end

   assign wr_en_o   = store_valid && store_flag;
   assign wr_data_o = in_data_i;

endmodule

// File: rtl/vwrite_top.sv
`timescale 1ns/1ns
`include "vwrite_settings.svh"

module vwrite_top (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   run_i,
   input  vwrite_pkg::write_cfg_t cfg_i,
   input  logic [`VW_DATA_W-1:0]  in_data_i,
   input  vwrite_pkg::bus_rsp_t   bus_rsp_i,
   output vwrite_pkg::bus_req_t   bus_req_o,
   output logic                   done_o
);

   logic                  wr_en;
   logic [`VW_ADDR_W-1:0] wr_addr;
   logic [`VW_DATA_W-1:0] wr_data;
   logic                  rd_en;
   logic [`VW_ADDR_W-1:0] rd_addr;
   logic [`VW_DATA_W-1:0] rd_data;

   vwrite_unit unit (
      .clk       (clk),
      .rst       (rst),
      .run_i     (run_i),
      .cfg_i     (cfg_i),
      .in_data_i (in_data_i),
      .bus_rsp_i (bus_rsp_i),
      .rd_data_i (rd_data),
      .done_o    (done_o),
      .bus_req_o (bus_req_o),
      .wr_en_o   (wr_en),
      .wr_addr_o (wr_addr),
      .wr_data_o (wr_data),
      .rd_en_o   (rd_en),
      .rd_addr_o (rd_addr)
   );

   buffer_ram buffer (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (wr_data),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

endmodule

// File: verification/vwrite_sva.sv
`timescale 1ns/1ns

module vwrite_sva (
   input logic                 clk,
   input logic                 rst,
   input vwrite_pkg::bus_req_t bus_req_i,
   input vwrite_pkg::bus_rsp_t bus_rsp_i,
   input logic                 done_i
);

   // A stalled beat must be offered again unchanged
   property beat_held_under_backpressure;
      @(posedge clk) disable iff (rst)
         bus_req_i.valid && !bus_rsp_i.ready |=> bus_req_i.valid && $stable(bus_req_i.wdata);
   endproperty

   property done_after_reset;
      @(posedge clk) $fell(rst) |-> done_i;
   endproperty

   property no_beat_while_done;
      @(posedge clk) disable iff (rst)
         done_i |-> !(bus_req_i.valid && bus_rsp_i.ready);
   endproperty

   assert property (beat_held_under_backpressure)
      else $error("databus valid or wdata changed while ready was low");
   assert property (done_after_reset)
      else $error("done_o is low after reset");
   assert property (no_beat_while_done)
      else $error("databus beat accepted while done_o is high");

endmodule

bind vwrite_top vwrite_sva sva (
   .clk       (clk),
   .rst       (rst),
   .bus_req_i (bus_req_o),
   .bus_rsp_i (bus_rsp_i),
   .done_i    (done_o)
);

// File: verification/vwrite_checker.sv
`timescale 1ns/1ns
`include "vwrite_settings.svh"

module vwrite_checker (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      run_i,
   input  logic                      done_i,
   input  vwrite_pkg::bus_req_t      bus_req_i,
   input  vwrite_pkg::bus_rsp_t      bus_rsp_i,
   input  logic [`VW_DATA_W-1:0]     exp_word_i,
   input  logic [`VW_EXT_ADDR_W-1:0] exp_addr_i,
   input  logic [`VW_LEN_W-1:0]      exp_len_i,
   input  int                        exp_count_i,
   input  int                        test_id_i,
   input  logic                      test_end_i,
   output int                        beat_idx_o,
   output int                        errors_o,
   output int                        passed_o,
   output int                        failed_o
);

   int   beat_idx = 0;
   int   errors = 0;
   int   passed = 0;
   int   failed = 0;
   int   test_errs = 0;
   logic run_q = 1'b0;

   assign beat_idx_o = beat_idx;
   assign errors_o   = errors;
   assign passed_o   = passed;
   assign failed_o   = failed;

   // Inputs and DUT outputs are settled at the falling edge
   always @(negedge clk) begin
      if (!rst) begin
         if (run_q && done_i) begin
            $display("[FAIL] %0t: done_o still high the cycle after run", $time);
            test_errs = test_errs + 1;
         end
         run_q = run_i;
         if (bus_req_i.valid && bus_rsp_i.ready) begin
            if (bus_req_i.addr !== exp_addr_i || bus_req_i.len !== exp_len_i) begin
               $display("[FAIL] %0t: beat %0d has addr %h len %h, expected %h len %h", $time,
                        beat_idx, bus_req_i.addr, bus_req_i.len, exp_addr_i, exp_len_i);
               test_errs = test_errs + 1;
            end
            if (beat_idx >= exp_count_i) begin
               $display("[FAIL] %0t: extra beat %0d with data %h", $time, beat_idx,
                        bus_req_i.wdata);
               test_errs = test_errs + 1;
            end else if (bus_req_i.wdata !== exp_word_i) begin
               $display("[FAIL] %0t: beat %0d carries %h, expected %h", $time, beat_idx,
                        bus_req_i.wdata, exp_word_i);
               test_errs = test_errs + 1;
            end
            beat_idx <= beat_idx + 1;
         end
         if (test_end_i) begin
            if (beat_idx != exp_count_i) begin
               $display("[FAIL] %0t: %0d beats seen, expected %0d", $time, beat_idx,
                        exp_count_i);
               test_errs = test_errs + 1;
            end
            if (test_errs == 0) begin
               passed <= passed + 1;
               $display("Test %0d: ok, %0d beats", test_id_i, beat_idx);
            end else begin
               failed <= failed + 1;
               $display("Test %0d: %0d errors, %0d beats", test_id_i, test_errs, beat_idx);
            end
            errors <= errors + test_errs;
            test_errs = 0;
            beat_idx <= 0;
         end
      end
   end

endmodule

// File: verification/vwrite_tb.sv
`timescale 1ns/1ns
`include "vwrite_settings.svh"

module vwrite_tb;

   localparam int PAT_WORDS = 512;

   logic                   clk = 1'b0;
   logic                   rst = 1'b1;
   logic                   run = 1'b0;
   vwrite_pkg::write_cfg_t cfg = '0;
   logic [`VW_DATA_W-1:0]  in_data = '0;
   vwrite_pkg::bus_rsp_t   bus_rsp = '0;
   vwrite_pkg::bus_req_t   bus_req;
   logic                   done;

   logic [31:0]               pat [0:PAT_WORDS-1];
   logic [`VW_DATA_W-1:0]     exp_word;
   logic [`VW_EXT_ADDR_W-1:0] exp_addr = '0;
   logic [`VW_LEN_W-1:0]      exp_len = '0;
   logic                      random_ready = 1'b0;
   logic                      test_end = 1'b0;
   int                        exp_base = 0;
   int                        exp_count = 0;
   int                        test_id = 0;
   int                        beat_idx;
   int                        errors;
   int                        passed;
   int                        failed;
   int                        taken = 0;
   int                        cycles = 0;
   int                        limit = 0;

   vwrite_top dut_i (
      .clk       (clk),
      .rst       (rst),
      .run_i     (run),
      .cfg_i     (cfg),
      .in_data_i (in_data),
      .bus_rsp_i (bus_rsp),
      .bus_req_o (bus_req),
      .done_o    (done)
   );

   assign exp_word = pat[exp_base + beat_idx];

   vwrite_checker chk (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run),
      .done_i      (done),
      .bus_req_i   (bus_req),
      .bus_rsp_i   (bus_rsp),
      .exp_word_i  (exp_word),
      .exp_addr_i  (exp_addr),
      .exp_len_i   (exp_len),
      .exp_count_i (exp_count),
      .test_id_i   (test_id),
      .test_end_i  (test_end),
      .beat_idx_o  (beat_idx),
      .errors_o    (errors),
      .passed_o    (passed),
      .failed_o    (failed)
   );

   initial begin
      forever #5 clk = !clk;
   end

   // Field order follows the pattern file columns
   function automatic vwrite_pkg::addr_gen_cfg_t gen_cfg_at(input int idx);
      vwrite_pkg::addr_gen_cfg_t c;
      c.start       = pat[idx][`VW_ADDR_W-1:0];
      c.period      = pat[idx+1][`VW_PERIOD_W-1:0];
      c.duty        = pat[idx+2][`VW_PERIOD_W-1:0];
      c.incr        = pat[idx+3][`VW_ADDR_W-1:0];
      c.iterations  = pat[idx+4][`VW_ADDR_W-1:0];
      c.shift       = pat[idx+5][`VW_ADDR_W-1:0];
      c.period2     = pat[idx+6][`VW_PERIOD_W-1:0];
      c.incr2       = pat[idx+7][`VW_ADDR_W-1:0];
      c.iterations2 = pat[idx+8][`VW_ADDR_W-1:0];
      c.shift2      = pat[idx+9][`VW_ADDR_W-1:0];
      c.delay       = pat[idx+10][`VW_DELAY_W-1:0];
      return c;
   endfunction

   // Databus slave that counts accepted beats and flags the final one
   always @(negedge clk) begin
      if (run) begin
         taken <= 0;
      end else if (bus_req.valid && bus_rsp.ready) begin
         taken <= taken + 1;
      end
   end

   always @(posedge clk) begin
      #1;
      bus_rsp.ready = random_ready ? (($urandom % 3) != 0) : 1'b1;
      bus_rsp.last  = bus_rsp.ready && (taken == int'(cfg.length));
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("Timeout: the run did not finish within %0d cycles", limit);
         $display("Result: FAILED");
         $finish;
      end
   end

   initial begin
      int p;
      int t;
      int i;
      int n_tests;
      int n_in;
      int n_exp;
      int dly;
      int budget;
      void'($urandom(37770));
      $readmemh("verification/vwrite_patterns.txt", pat);
      n_tests = int'(pat[0]);
      budget = 10;
      p = 1;
      for (t = 0; t < n_tests; t++) begin
         n_in  = int'(pat[p+5]);
         n_exp = int'(pat[p+6]);
         budget = budget + 4 * (n_in + n_exp + int'(pat[p+17]) + int'(pat[p+28])) + 50;
         p = p + 29 + n_in + n_exp;
      end
      limit = budget;
      repeat (2) @(posedge clk);
      #1 rst = 1'b0;
      p = 1;
      for (t = 0; t < n_tests; t++) begin
         random_ready      = pat[p][0];
         cfg.write_enabled = pat[p+1][0];
         cfg.ping_pong     = pat[p+2][0];
         cfg.ext_addr      = pat[p+3];
         cfg.length        = pat[p+4][`VW_LEN_W-1:0];
         n_in              = int'(pat[p+5]);
         n_exp             = int'(pat[p+6]);
         cfg.store         = gen_cfg_at(p + 7);
         cfg.send          = gen_cfg_at(p + 18);
         dly               = int'(cfg.store.delay);
         exp_addr          = pat[p+3];
         exp_len           = pat[p+4][`VW_LEN_W-1:0];
         exp_base          = p + 29 + n_in;
         exp_count         = n_exp;
         test_id           = t + 1;
         @(posedge clk);
         #1 run = 1'b1;
         @(posedge clk);
         #1 run = 1'b0;
         // One stream word per store position, starting after the delay
         for (i = 0; i < dly + n_in; i++) begin
            if (i >= dly) begin
               in_data = pat[p + 29 + i - dly];
            end
            @(posedge clk);
            #1;
         end
         in_data = '0;
         while (!done) begin
            @(posedge clk);
            #1;
         end
         test_end = 1'b1;
         @(posedge clk);
         #1 test_end = 1'b0;
         p = p + 29 + n_in + n_exp;
      end
      @(posedge clk);
      #1;
      $display("Closing: %0d tests passed, %0d failed, %0d errors", passed, failed, errors);
      if (errors == 0 && failed == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// File: verification/vwrite_patterns.txt
// First word: test count. Per test, all hex:
// mode(1=random ready) write_enabled ping_pong ext_addr length n_in n_exp
// store cfg: start period duty incr iterations shift period2 incr2 iterations2 shift2 delay
// send cfg: same columns (start ignored); then n_in input words, then n_exp beat words
6
// Linear store then send
0 1 0 a0000000 7 8 8
0 4 4 1 2 1 1 0 1 0 0
0 4 4 1 2 1 1 0 1 0 1
1001 1002 1003 1004 1005 1006 1007 1008
1001 1002 1003 1004 1005 1006 1007 1008
// Strided patterns, duty below period and a second loop level
0 1 0 a0000100 7 c 8
0 3 2 2 2 5 2 20 1 40 2
0 2 2 20 2 e2 2 9 1 0 a
2001 2002 2003 2004 2005 2006 2007 2008 2009 200a 200b 200c
2001 2007 2002 2008 2004 200a 2005 200b
// Same patterns under random back-pressure
1 1 0 a0000180 7 c 8
0 3 2 2 2 5 2 20 1 40 2
0 2 2 20 2 e2 2 9 1 0 a
2001 2002 2003 2004 2005 2006 2007 2008 2009 200a 200b 200c
2001 2007 2002 2008 2004 200a 2005 200b
// Ping-pong run with write_enabled low, store only
0 0 1 a0000200 3 4 0
0 4 4 1 1 0 1 0 1 0 0
0 4 4 1 1 0 1 0 1 0 1
3001 3002 3003 3004
// Ping-pong, sends the half stored by the previous run
0 1 1 a0000300 3 4 4
0 4 4 1 1 0 1 0 1 0 0
0 4 4 1 1 0 1 0 1 0 1
4001 4002 4003 4004
3001 3002 3003 3004
1 1 1 a0000400 3 4 4
0 4 4 1 1 0 1 0 1 0 0
0 4 4 1 1 0 1 0 1 0 1
5001 5002 5003 5004
4001 4002 4003 4004

// File: sources.f
+incdir+rtl
rtl/vwrite_pkg.sv
rtl/address_gen.sv
rtl/memory_reader.sv
rtl/buffer_ram.sv
rtl/vwrite_unit.sv
rtl/vwrite_top.sv
verification/vwrite_sva.sv
verification/vwrite_checker.sv
verification/vwrite_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds with Verilator and runs the testbench from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module vwrite_tb -o vwrite_sim \
   && ./obj_dir/vwrite_sim | tee /dev/stderr | grep -q "Result: PASSED" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
